// File: Bender.yml
package:
  name: exec_cluster

sources:
  # shared package
  - common/iq_pkg.sv
  # rtl
  - src/int_alu.sv
  - issue_queue/iq_entry.sv
  - issue_queue/alu_iq.sv
  - src/cdb_arbiter.sv
  - src/exec_cluster.sv
  # testbench
  - target: test
    files:
      - testbench/tb_exec_cluster.sv

// File: common/iq_pkg.sv
package iq_pkg;

    // ------------------------------------------------------------------
    // datapath widths
    // ------------------------------------------------------------------

    // integer data width
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;

    // producer tag width
    localparam int TAG_W = 5;

    typedef logic [TAG_W-1:0] tag_t;

    // ------------------------------------------------------------------
    // queue and bus sizes
    // ------------------------------------------------------------------

    // entries per issue queue, select tree assumes four
    localparam int IQ_SIZE  = 4;
    localparam int IQ_IDX_W = $clog2(IQ_SIZE);

    // one-hot shift age, saturates at its top bit
    localparam int AGING_W = 4;

    // issue queues sharing the cdb
    localparam int NUM_IQ    = 2;
    localparam int ARB_IDX_W = $clog2(NUM_IQ);

    // shift amount taken from operand 1
    localparam int SHAMT_W = $clog2(XLEN);

    // ------------------------------------------------------------------
    // alu opcodes
    // ------------------------------------------------------------------

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        // logical shifts by the low bits of operand 1
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        // signed compare, result is 1 or 0
        ALU_SLT = 3'd7
    } alu_op_e;

endpackage

// File: issue_queue/alu_iq.sv
`timescale 1ns/1ps

module alu_iq (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             flush_i,
    input  logic             dispatch_valid_i,
    input  iq_pkg::alu_op_e  dispatch_op_i,
    input  iq_pkg::tag_t     dispatch_tag_i,
    input  iq_pkg::word_t    src0_value_i,
    input  iq_pkg::word_t    src1_value_i,
    input  iq_pkg::tag_t     src0_tag_i,
    input  iq_pkg::tag_t     src1_tag_i,
    input  logic             src0_ready_i,
    input  logic             src1_ready_i,
    input  logic             cdb_valid_i,
    input  iq_pkg::tag_t     cdb_tag_i,
    input  iq_pkg::word_t    cdb_value_i,
    input  logic             grant_i,
    output logic             iq_ready_o,
    output logic             slot_valid_o,
    output iq_pkg::tag_t     slot_tag_o,
    output iq_pkg::word_t    slot_value_o
);

    import iq_pkg::*;

    logic [IQ_SIZE-1:0] ent_busy;
    logic [IQ_SIZE-1:0] ent_ready;
    logic [IQ_SIZE-1:0] alloc_vec;
    logic [IQ_SIZE-1:0] issue_vec;
    alu_op_e            ent_op  [IQ_SIZE];
    tag_t               ent_tag [IQ_SIZE];
    word_t              ent_a   [IQ_SIZE];
    word_t              ent_b   [IQ_SIZE];

    // ------------------------------------------------------------------
    // allocation into the lowest free slot
    // ------------------------------------------------------------------
    always_comb begin
        logic found;
        found     = 1'b0;
        alloc_vec = '0;
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (!found && !ent_busy[i]) begin
                found        = 1'b1;
                alloc_vec[i] = dispatch_valid_i;
            end
        end
    end

    assign iq_ready_o = ~&ent_busy;

    for (genvar i = 0; i < IQ_SIZE; i++) begin : gen_entry
        iq_entry i_iq_entry (
            .clk            (clk),
            .rst_n_i        (rst_n_i),
            .flush_i        (flush_i),
            .alloc_i        (alloc_vec[i]),
            .issue_i        (issue_vec[i]),
            .dispatch_op_i  (dispatch_op_i),
            .dispatch_tag_i (dispatch_tag_i),
            .src0_value_i   (src0_value_i),
            .src1_value_i   (src1_value_i),
            .src0_tag_i     (src0_tag_i),
            .src1_tag_i     (src1_tag_i),
            .src0_ready_i   (src0_ready_i),
            .src1_ready_i   (src1_ready_i),
            .cdb_valid_i    (cdb_valid_i),
            .cdb_tag_i      (cdb_tag_i),
            .cdb_value_i    (cdb_value_i),
            .busy_o         (ent_busy[i]),
            .ready_o        (ent_ready[i]),
            .op_o           (ent_op[i]),
            .tag_o          (ent_tag[i]),
            .opnd0_o        (ent_a[i]),
            .opnd1_o        (ent_b[i])
        );
    end

    // ------------------------------------------------------------------
    // aging and oldest-ready select
    // ------------------------------------------------------------------
    logic [AGING_W-1:0]  age_q [IQ_SIZE];
    logic [AGING_W:0]    key   [IQ_SIZE];
    logic [IQ_IDX_W-1:0] pick_lo;
    logic [IQ_IDX_W-1:0] pick_hi;
    logic [IQ_IDX_W-1:0] pick;
    logic                slot_valid_q;
    logic                issue_fire;

    always_ff @(posedge clk) begin
        for (int i = 0; i < IQ_SIZE; i++) begin
            if (!rst_n_i || flush_i || issue_vec[i] || alloc_vec[i]) begin
                age_q[i] <= '0;
            end else if (age_q[i] == '0) begin
                age_q[i] <= AGING_W'(1);
            end else if (!age_q[i][AGING_W-1]) begin
                age_q[i] <= age_q[i] << 1;
            end
        end
    end

    // ready bit on top so any ready entry beats any age
    always_comb begin
        for (int i = 0; i < IQ_SIZE; i++) begin
            key[i] = {ent_ready[i], age_q[i]};
        end
    end

    assign pick_lo = (key[1] > key[0]) ? IQ_IDX_W'(1) : IQ_IDX_W'(0);
    assign pick_hi = (key[3] > key[2]) ? IQ_IDX_W'(3) : IQ_IDX_W'(2);
    assign pick    = (key[pick_lo] >= key[pick_hi]) ? pick_lo : pick_hi;

    // issue only into an empty or draining output slot
    assign issue_fire = ent_ready[pick] && (!slot_valid_q || grant_i);

    always_comb begin
        issue_vec = '0;
        issue_vec[pick] = issue_fire;
    end

    // ------------------------------------------------------------------
    // alu and output slot
    // ------------------------------------------------------------------
    word_t alu_res;

    int_alu i_int_alu (
        .op_i  (ent_op[pick]),
        .a_i   (ent_a[pick]),
        .b_i   (ent_b[pick]),
        .res_o (alu_res)
    );

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            slot_valid_q <= 1'b0;
        end else if (issue_fire) begin
            slot_valid_q <= 1'b1;
        end else if (grant_i) begin
            slot_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            slot_tag_o   <= ent_tag[pick];
            slot_value_o <= alu_res;
        end
    end

    assign slot_valid_o = slot_valid_q;

    a_no_dispatch_when_full: assert property (
        @(posedge clk) disable iff (!rst_n_i) dispatch_valid_i |-> iq_ready_o)
        else $error("alu_iq: dispatch into a full queue");

    // at most one entry frees per cycle outside a flush
    a_single_issue: assert property (
        @(posedge clk) disable iff (!rst_n_i)
            !flush_i |=> $onehot0($past(ent_busy) & ~ent_busy))
        else $error("alu_iq: more than one entry issued");

endmodule

// File: issue_queue/iq_entry.sv
`timescale 1ns/1ps

module iq_entry (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             flush_i,
    input  logic             alloc_i,
    input  logic             issue_i,
    input  iq_pkg::alu_op_e  dispatch_op_i,
    input  iq_pkg::tag_t     dispatch_tag_i,
    input  iq_pkg::word_t    src0_value_i,
    input  iq_pkg::word_t    src1_value_i,
    input  iq_pkg::tag_t     src0_tag_i,
    input  iq_pkg::tag_t     src1_tag_i,
    input  logic             src0_ready_i,
    input  logic             src1_ready_i,
    input  logic             cdb_valid_i,
    input  iq_pkg::tag_t     cdb_tag_i,
    input  iq_pkg::word_t    cdb_value_i,
    output logic             busy_o,
    output logic             ready_o,
    output iq_pkg::alu_op_e  op_o,
    output iq_pkg::tag_t     tag_o,
    output iq_pkg::word_t    opnd0_o,
    output iq_pkg::word_t    opnd1_o
);

    import iq_pkg::*;

    logic    busy_q;
    alu_op_e op_q;
    tag_t    tag_q;

    // per operand state, index 0 and 1
    tag_t  src_tag_in [2];
    word_t src_val_in [2];
    logic  src_rdy_in [2];
    tag_t  opnd_tag_q [2];
    word_t opnd_val_q [2];
    logic  opnd_rdy_q [2];

    assign src_tag_in[0] = src0_tag_i;
    assign src_tag_in[1] = src1_tag_i;
    assign src_val_in[0] = src0_value_i;
    assign src_val_in[1] = src1_value_i;
    assign src_rdy_in[0] = src0_ready_i;
    assign src_rdy_in[1] = src1_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            busy_q     <= 1'b0;
            opnd_rdy_q <= '{1'b0, 1'b0};
        end else if (alloc_i) begin
            busy_q <= 1'b1;
            op_q   <= dispatch_op_i;
            tag_q  <= dispatch_tag_i;
            for (int i = 0; i < 2; i++) begin
                opnd_tag_q[i] <= src_tag_in[i];
                if (src_rdy_in[i]) begin
                    opnd_val_q[i] <= src_val_in[i];
                    opnd_rdy_q[i] <= 1'b1;
                end else if (cdb_valid_i && cdb_tag_i == src_tag_in[i]) begin
                    // producer broadcasts in the dispatch cycle
                    opnd_val_q[i] <= cdb_value_i;
                    opnd_rdy_q[i] <= 1'b1;
                end else begin
                    opnd_rdy_q[i] <= 1'b0;
                end
            end
        end else if (issue_i) begin
            busy_q <= 1'b0;
        end else begin
            // wakeup of waiting operands
            for (int i = 0; i < 2; i++) begin
                if (busy_q && !opnd_rdy_q[i] && cdb_valid_i &&
                    cdb_tag_i == opnd_tag_q[i]) begin
                    opnd_val_q[i] <= cdb_value_i;
                    opnd_rdy_q[i] <= 1'b1;
                end
            end
        end
    end

    assign busy_o  = busy_q;
    assign ready_o = busy_q && opnd_rdy_q[0] && opnd_rdy_q[1];
    assign op_o    = op_q;
    assign tag_o   = tag_q;
    assign opnd0_o = opnd_val_q[0];
    assign opnd1_o = opnd_val_q[1];

endmodule

// File: src.f
common/iq_pkg.sv
src/int_alu.sv
issue_queue/iq_entry.sv
issue_queue/alu_iq.sv
src/cdb_arbiter.sv
src/exec_cluster.sv
testbench/tb_exec_cluster.sv

// File: src/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter (
    input  logic                                 clk,
    input  logic                                 rst_n_i,
    input  logic                                 flush_i,
    input  logic          [iq_pkg::NUM_IQ-1:0]   slot_valid_i,
    input  iq_pkg::tag_t  [iq_pkg::NUM_IQ-1:0]   slot_tag_i,
    input  iq_pkg::word_t [iq_pkg::NUM_IQ-1:0]   slot_value_i,
    output logic          [iq_pkg::NUM_IQ-1:0]   grant_o,
    output logic                                 cdb_valid_o,
    output iq_pkg::tag_t                         cdb_tag_o,
    output iq_pkg::word_t                        cdb_value_o
);

    import iq_pkg::*;

    logic [ARB_IDX_W-1:0] last_q;
    logic [ARB_IDX_W-1:0] win_idx;
    logic                 found;

    // search starts just after the last winner
    always_comb begin
        int unsigned cand;
        grant_o = '0;
        win_idx = '0;
        found   = 1'b0;
        for (int k = 1; k <= NUM_IQ; k++) begin
            cand = (int'(last_q) + k) % NUM_IQ;
            if (!found && slot_valid_i[cand]) begin
                found         = 1'b1;
                grant_o[cand] = 1'b1;
                win_idx       = ARB_IDX_W'(cand);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            last_q <= ARB_IDX_W'(NUM_IQ - 1);
        end else if (found) begin
            last_q <= win_idx;
        end
    end

    // ------------------------------------------------------------------
    // cdb drive
    // ------------------------------------------------------------------
    assign cdb_valid_o = found;
    assign cdb_tag_o   = slot_tag_i[win_idx];
    assign cdb_value_o = slot_value_i[win_idx];

    a_grant_onehot: assert property (
        @(posedge clk) disable iff (!rst_n_i)
            $onehot0(grant_o) && ((grant_o & ~slot_valid_i) == '0))
        else $error("cdb_arbiter: grant not one-hot or to an empty slot");

endmodule

// File: src/exec_cluster.sv
`timescale 1ns/1ps

module exec_cluster (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic                         flush_i,
    input  logic [iq_pkg::NUM_IQ-1:0]    dispatch_valid_i,
    input  iq_pkg::alu_op_e              dispatch_op_i,
    input  iq_pkg::tag_t                 dispatch_tag_i,
    input  iq_pkg::word_t                src0_value_i,
    input  iq_pkg::tag_t                 src0_tag_i,
    input  logic                         src0_ready_i,
    input  iq_pkg::word_t                src1_value_i,
    input  iq_pkg::tag_t                 src1_tag_i,
    input  logic                         src1_ready_i,
    output logic [iq_pkg::NUM_IQ-1:0]    iq_ready_o,
    output logic                         cdb_valid_o,
    output iq_pkg::tag_t                 cdb_tag_o,
    output iq_pkg::word_t                cdb_value_o
);

    import iq_pkg::*;

    logic  [NUM_IQ-1:0] slot_valid;
    tag_t  [NUM_IQ-1:0] slot_tag;
    word_t [NUM_IQ-1:0] slot_value;
    logic  [NUM_IQ-1:0] grant;

    // every queue sees the same cdb for wakeup
    for (genvar k = 0; k < NUM_IQ; k++) begin : gen_iq
        alu_iq i_alu_iq (
            .clk              (clk),
            .rst_n_i          (rst_n_i),
            .flush_i          (flush_i),
            .dispatch_valid_i (dispatch_valid_i[k]),
            .dispatch_op_i    (dispatch_op_i),
            .dispatch_tag_i   (dispatch_tag_i),
            .src0_value_i     (src0_value_i),
            .src1_value_i     (src1_value_i),
            .src0_tag_i       (src0_tag_i),
            .src1_tag_i       (src1_tag_i),
            .src0_ready_i     (src0_ready_i),
            .src1_ready_i     (src1_ready_i),
            .cdb_valid_i      (cdb_valid_o),
            .cdb_tag_i        (cdb_tag_o),
            .cdb_value_i      (cdb_value_o),
            .grant_i          (grant[k]),
            .iq_ready_o       (iq_ready_o[k]),
            .slot_valid_o     (slot_valid[k]),
            .slot_tag_o       (slot_tag[k]),
            .slot_value_o     (slot_value[k])
        );
    end

    cdb_arbiter i_cdb_arbiter (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .slot_valid_i (slot_valid),
        .slot_tag_i   (slot_tag),
        .slot_value_i (slot_value),
        .grant_o      (grant),
        .cdb_valid_o  (cdb_valid_o),
        .cdb_tag_o    (cdb_tag_o),
        .cdb_value_o  (cdb_value_o)
    );

endmodule

// File: src/int_alu.sv
`timescale 1ns/1ps

module int_alu (
    input  iq_pkg::alu_op_e op_i,
    input  iq_pkg::word_t   a_i,
    input  iq_pkg::word_t   b_i,
    output iq_pkg::word_t   res_o
);

    import iq_pkg::*;

    logic [SHAMT_W-1:0] shamt;
    logic               lt;

    assign shamt = b_i[SHAMT_W-1:0];
    assign lt    = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            ALU_ADD: begin
                res_o = a_i + b_i;
            end
            ALU_SUB: begin
                res_o = a_i - b_i;
            end
            ALU_AND: begin
                res_o = a_i & b_i;
            end
            ALU_OR: begin
                res_o = a_i | b_i;
            end
            ALU_XOR: begin
                res_o = a_i ^ b_i;
            end
            ALU_SLL: begin
                res_o = a_i << shamt;
            end
            ALU_SRL: begin
                res_o = a_i >> shamt;
            end
            ALU_SLT: begin
                res_o = {{(XLEN-1){1'b0}}, lt};
            end
            default: begin
                res_o = '0;
            end
        endcase
    end

endmodule

// File: testbench/exec_patterns.txt
# D queue op dest_tag rdy0 val_or_tag0 rdy1 val_or_tag1 expected   (tags and values in hex)
# I idle_cycles, Q queue expected_iq_ready, W drain and check, F flush
# independent work on both queues
D 0 ADD 01 1 00000005 1 00000007 0000000c
D 1 SUB 02 1 00000010 1 00000003 0000000d
D 0 XOR 03 1 0000ff00 1 00f0f000 00f00f00
D 1 SLL 04 1 00000003 1 00000004 00000030
D 0 SRL 05 1 80000000 1 0000001f 00000001
D 1 SLT 06 1 fffffffe 1 00000001 00000001
D 0 AND 07 1 f0f0f0f0 1 ff00ff00 f000f000
D 1 OR  08 1 12340000 1 00005678 12345678
W
# dependent chain crossing the queues
D 0 ADD 09 1 00000001 1 00000002 00000003
D 1 SLL 0a 0 09 1 00000002 0000000c
D 0 SUB 0b 0 0a 0 09 00000009
D 1 SLT 0c 1 00000005 0 0b 00000001
D 0 XOR 0d 0 0c 0 0a 0000000d
W
# queue 0 fills up waiting on tag 0e
D 0 ADD 0f 0 0e 1 00000001 00000124
D 0 SUB 10 0 0e 1 00000003 00000120
D 0 SLL 11 0 0e 1 00000004 00001230
D 0 OR  12 0 0e 1 00000f00 00000f23
Q 0 0
Q 1 1
D 1 ADD 0e 1 00000100 1 00000023 00000123
W
# burst released by tag 13, both queues contend for the cdb
D 0 ADD 14 0 13 1 00000001 00000043
D 0 SUB 15 0 13 1 00000002 00000040
D 0 SLL 16 0 13 1 00000001 00000084
D 1 XOR 17 0 13 1 000000ff 000000bd
D 1 AND 18 0 13 1 0000000f 00000002
D 1 SLT 19 0 13 1 00000100 00000001
D 1 ADD 1a 0 14 0 17 00000100
Q 1 0
D 0 ADD 13 1 00000040 1 00000002 00000042
W
# flush with work stuck on a tag that never comes
D 0 ADD 1e 1 00000001 1 00000001 00000002
D 0 ADD 1c 0 1b 1 00000001 00000000
D 1 SUB 1d 0 1b 1 00000001 00000000
I 4
F
D 0 ADD 1f 1 00000007 1 00000008 0000000f
D 1 SUB 00 0 1f 1 00000005 0000000a
W

// File: testbench/tb_exec_cluster.sv
`timescale 1ns/1ps

module tb_exec_cluster;

    import iq_pkg::*;

    localparam int MAX_REC  = 64;
    localparam int NUM_TAGS = 1 << TAG_W;
    localparam int ST_FREE  = 0;
    localparam int ST_PEND  = 1;
    localparam int ST_DONE  = 2;
    localparam int ST_FLUSH = 3;

    logic              clk;
    logic              rst_n_i;
    logic              flush_i;
    logic [NUM_IQ-1:0] dispatch_valid_i;
    alu_op_e           dispatch_op_i;
    tag_t              dispatch_tag_i;
    word_t             src0_value_i;
    tag_t              src0_tag_i;
    logic              src0_ready_i;
    word_t             src1_value_i;
    tag_t              src1_tag_i;
    logic              src1_ready_i;
    logic [NUM_IQ-1:0] iq_ready_o;
    logic              cdb_valid_o;
    tag_t              cdb_tag_o;
    word_t             cdb_value_o;

    // records as read from the pattern file
    logic [7:0] rec_kind [MAX_REC];
    int         rec_q    [MAX_REC];
    int         rec_n    [MAX_REC];
    alu_op_e    rec_op   [MAX_REC];
    tag_t       rec_tag  [MAX_REC];
    logic       rec_r0   [MAX_REC];
    logic       rec_r1   [MAX_REC];
    word_t      rec_v0   [MAX_REC];
    word_t      rec_v1   [MAX_REC];
    word_t      rec_exp  [MAX_REC];
    int         n_rec;
    logic       loaded;

    // scoreboard, one slot per tag
    int     tag_state [NUM_TAGS];
    int     tag_rec   [NUM_TAGS];
    word_t  result_sb [NUM_TAGS];
    int     n_pending;
    integer seed;

    exec_cluster i_exec_cluster (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_op_i    (dispatch_op_i),
        .dispatch_tag_i   (dispatch_tag_i),
        .src0_value_i     (src0_value_i),
        .src0_tag_i       (src0_tag_i),
        .src0_ready_i     (src0_ready_i),
        .src1_value_i     (src1_value_i),
        .src1_tag_i       (src1_tag_i),
        .src1_ready_i     (src1_ready_i),
        .iq_ready_o       (iq_ready_o),
        .cdb_valid_o      (cdb_valid_o),
        .cdb_tag_o        (cdb_tag_o),
        .cdb_value_o      (cdb_value_o)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // ------------------------------------------------------------------
    // reference model and helpers
    // ------------------------------------------------------------------
    function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return 'x;
        endcase
    endfunction

    // bit 3 set means unknown mnemonic
    function automatic logic [3:0] decode_op(input logic [31:0] name);
        case (name)
            "ADD":   return {1'b0, ALU_ADD};
            "SUB":   return {1'b0, ALU_SUB};
            "AND":   return {1'b0, ALU_AND};
            "OR":    return {1'b0, ALU_OR};
            "XOR":   return {1'b0, ALU_XOR};
            "SLL":   return {1'b0, ALU_SLL};
            "SRL":   return {1'b0, ALU_SRL};
            "SLT":   return {1'b0, ALU_SLT};
            default: return 4'b1000;
        endcase
    endfunction

    // operand is known once its producer has broadcast
    function automatic logic operand_known(input logic rdy, input word_t v);
        return rdy || (tag_state[v[TAG_W-1:0]] == ST_DONE);
    endfunction

    function automatic word_t operand_value(input logic rdy, input word_t v);
        return rdy ? v : result_sb[v[TAG_W-1:0]];
    endfunction

    task automatic fail_run(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Result: FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // ------------------------------------------------------------------
    // pattern file
    // ------------------------------------------------------------------
    task automatic load_patterns();
        integer           fd;
        integer           cnt;
        logic [63:0]      kind;
        logic [31:0]      op_name;
        logic [3:0]       op_code;
        logic [8*200-1:0] line;
        integer           q;
        integer           n;
        integer           r0;
        integer           r1;
        logic [31:0]      t;
        logic [31:0]      v0;
        logic [31:0]      v1;
        logic [31:0]      e;
        logic             at_end;
        fd = $fopen("testbench/exec_patterns.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open testbench/exec_patterns.txt");
        end
        at_end = 1'b0;
        n_rec  = 0;
        while (!at_end) begin
            if ($fscanf(fd, " %s", kind) != 1) begin
                at_end = 1'b1;
            end else if (kind == "#") begin
                cnt = $fgets(line, fd);
            end else begin
                if (n_rec >= MAX_REC) begin
                    fail_run("too many records in the pattern file");
                end
                rec_kind[n_rec] = kind[7:0];
                if (kind == "D") begin
                    cnt = $fscanf(fd, " %d %s %h %d %h %d %h %h",
                                  q, op_name, t, r0, v0, r1, v1, e);
                    op_code = decode_op(op_name);
                    if (cnt != 8 || op_code[3]) begin
                        fail_run("malformed dispatch record in the pattern file");
                    end
                    rec_q[n_rec]   = q;
                    rec_op[n_rec]  = alu_op_e'(op_code[2:0]);
                    rec_tag[n_rec] = t[TAG_W-1:0];
                    rec_r0[n_rec]  = (r0 != 0);
                    rec_v0[n_rec]  = v0;
                    rec_r1[n_rec]  = (r1 != 0);
                    rec_v1[n_rec]  = v1;
                    rec_exp[n_rec] = e;
                end else if (kind == "I") begin
                    cnt = $fscanf(fd, " %d", n);
                    rec_n[n_rec] = n;
                end else if (kind == "Q") begin
                    cnt = $fscanf(fd, " %d %d", q, n);
                    rec_q[n_rec] = q;
                    rec_n[n_rec] = n;
                end else if (kind != "W" && kind != "F") begin
                    fail_run("unknown record kind in the pattern file");
                end
                n_rec++;
            end
        end
        $fclose(fd);
        loaded = 1'b1;
    endtask

    // ------------------------------------------------------------------
    // dispatch driver and control records
    // ------------------------------------------------------------------
    task automatic dispatch_record(input int r);
        int   q;
        tag_t t;
        int   gap;
        q = rec_q[r];
        t = rec_tag[r];
        @(negedge clk);
        while (!iq_ready_o[q]) begin
            @(negedge clk);
        end
        @(posedge clk);
        if (tag_state[t] == ST_PEND) begin
            fail_run($sformatf("tag %0h dispatched again while in flight", t));
        end
        tag_state[t] = ST_PEND;
        tag_rec[t]   = r;
        n_pending++;
        // a producer already seen on the cdb is passed as a value
        dispatch_valid_i <= NUM_IQ'(1) << q;
        dispatch_op_i    <= rec_op[r];
        dispatch_tag_i   <= t;
        src0_ready_i     <= operand_known(rec_r0[r], rec_v0[r]);
        src0_value_i     <= operand_value(rec_r0[r], rec_v0[r]);
        src0_tag_i       <= rec_v0[r][TAG_W-1:0];
        src1_ready_i     <= operand_known(rec_r1[r], rec_v1[r]);
        src1_value_i     <= operand_value(rec_r1[r], rec_v1[r]);
        src1_tag_i       <= rec_v1[r][TAG_W-1:0];
        @(posedge clk);
        dispatch_valid_i <= '0;
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) @(posedge clk);
    endtask

    task automatic flush_all();
        @(posedge clk);
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (tag_state[t] == ST_PEND) begin
                tag_state[t] = ST_FLUSH;
            end
        end
        n_pending = 0;
        @(negedge clk);
        check_value("cdb_valid_o", cdb_valid_o, '0);
        check_value("iq_ready_o", iq_ready_o, 32'd3);
    endtask

    task automatic drain_results();
        while (n_pending != 0) begin
            @(posedge clk);
        end
        @(negedge clk);
        check_value("cdb_valid_o", cdb_valid_o, '0);
        check_value("iq_ready_o", iq_ready_o, 32'd3);
    endtask

    // ------------------------------------------------------------------
    // cdb monitor and scoreboard
    // ------------------------------------------------------------------
    task automatic check_broadcast(input tag_t t, input word_t got);
        int    r;
        word_t a;
        word_t b;
        word_t exp;
        if (tag_state[t] == ST_FLUSH) begin
            fail_run($sformatf("stale tag %0h on the cdb after a flush", t));
        end
        if (tag_state[t] != ST_PEND) begin
            fail_run($sformatf("unknown or repeated tag %0h on the cdb", t));
        end
        r = tag_rec[t];
        if ((!rec_r0[r] && tag_state[rec_v0[r][TAG_W-1:0]] != ST_DONE) ||
            (!rec_r1[r] && tag_state[rec_v1[r][TAG_W-1:0]] != ST_DONE)) begin
            fail_run($sformatf("tag %0h on the cdb before its producer", t));
        end
        a   = operand_value(rec_r0[r], rec_v0[r]);
        b   = operand_value(rec_r1[r], rec_v1[r]);
        exp = alu_model(rec_op[r], a, b);
        check_value("expected value in pattern file", rec_exp[r], exp);
        check_value($sformatf("cdb_value_o (tag %0h)", t), got, exp);
        result_sb[t] = exp;
        tag_state[t] = ST_DONE;
        n_pending--;
    endtask

    // cdb is settled by the falling edge
    always @(negedge clk) begin
        if (rst_n_i && cdb_valid_o) begin
            check_broadcast(cdb_tag_o, cdb_value_o);
        end
    end

    // 200 cycles for each record
    initial begin
        wait (loaded === 1'b1);
        repeat (200 * n_rec) @(posedge clk);
        fail_run("watchdog expired before all records were processed");
    end

    initial begin
        seed             = 32'hcdc1;
        rst_n_i          = 1'b0;
        flush_i          = 1'b0;
        dispatch_valid_i = '0;
        dispatch_op_i    = ALU_ADD;
        dispatch_tag_i   = '0;
        src0_value_i     = '0;
        src0_tag_i       = '0;
        src0_ready_i     = 1'b0;
        src1_value_i     = '0;
        src1_tag_i       = '0;
        src1_ready_i     = 1'b0;
        loaded           = 1'b0;
        n_pending        = 0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            tag_state[t] = ST_FREE;
        end
        load_patterns();
        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        check_value("cdb_valid_o", cdb_valid_o, '0);
        check_value("iq_ready_o", iq_ready_o, 32'd3);
        for (int r = 0; r < n_rec; r++) begin
            case (rec_kind[r])
                "D": dispatch_record(r);
                "I": repeat (rec_n[r]) @(posedge clk);
                "Q": begin
                    @(negedge clk);
                    check_value($sformatf("iq_ready_o[%0d]", rec_q[r]),
                                iq_ready_o[rec_q[r]], rec_n[r]);
                end
                "W": drain_results();
                "F": flush_all();
                default: ;
            endcase
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule
